/* vga_sram_pkg.sv */
`default_nettype none

package vga_sram_pkg;

  // Width of one word in the pixel FIFO
  localparam int PIXEL_WORD_WIDTH = 14;

  // Sync pulses are active low
  localparam logic SYNC_ACTIVE = 1'b0;

  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } color_t;

  // hsync and vsync on top, then the color
  typedef struct packed {
    logic   hsync;
    logic   vsync;
    color_t color;
  } pixel_word_t;

  // SRAM request kinds, also the controller state
  typedef enum logic [1:0] {
    REQ_IDLE  = 2'd0,
    REQ_WRITE = 2'd1,
    REQ_READ  = 2'd2
  } req_op_t;

  // Frame-buffer fill rule
  function automatic color_t pattern_color(input logic [31:0] addr, input logic [15:0] seed);
    return color_t'(addr[11:0] ^ seed[11:0]);
  endfunction

endpackage

`default_nettype wire

/* sram_controller.sv */
`timescale 1ns/100ps
`default_nettype none

module sram_controller import vga_sram_pkg::*; #(
  parameter int ADDR_WIDTH = 20,
  parameter int DATA_WIDTH = 16
) (
  input  wire                   clk,
  input  wire                   rst,
  input  wire  [ADDR_WIDTH-1:0] wr_addr,
  input  wire  [DATA_WIDTH-1:0] wr_data,
  input  wire                   wr_valid,
  output logic                  wr_ready,
  input  wire  [ADDR_WIDTH-1:0] rd_addr,
  input  wire                   rd_valid,
  output logic                  rd_ready,
  output logic [DATA_WIDTH-1:0] rd_data,
  output logic                  rd_data_valid,
  output logic [ADDR_WIDTH-1:0] sram_addr,
  inout  wire  [DATA_WIDTH-1:0] sram_data,
  output logic                  sram_we_n,
  output logic                  sram_oe_n,
  output logic                  sram_ce_n
);

  req_op_t               state;
  logic                  phase;
  logic                  drive;
  logic [DATA_WIDTH-1:0] wdata_q;

  // Writes win when both channels ask
  assign wr_ready = (state == REQ_IDLE);
  assign rd_ready = (state == REQ_IDLE) && !wr_valid;

  // Bus driven only while we_n is low
  assign sram_data = drive ? wdata_q : 'z;

  always_ff @(posedge clk) begin
    rd_data_valid <= 1'b0;
    if (rst) begin
      state     <= REQ_IDLE;
      phase     <= 1'b0;
      drive     <= 1'b0;
      sram_ce_n <= 1'b1;
      sram_we_n <= 1'b1;
      sram_oe_n <= 1'b1;
    end else begin
      case (state)
        REQ_IDLE: begin
          phase <= 1'b0;
          if (wr_valid) begin
            state     <= REQ_WRITE;
            sram_addr <= wr_addr;
            wdata_q   <= wr_data;
            sram_ce_n <= 1'b0;
            sram_we_n <= 1'b0;
            drive     <= 1'b1;
          end else if (rd_valid) begin
            state     <= REQ_READ;
            sram_addr <= rd_addr;
            sram_ce_n <= 1'b0;
            sram_oe_n <= 1'b0;
          end
        end
        REQ_WRITE: begin
          if (!phase) begin
            // we_n rises, address and ce_n held one more cycle
            phase     <= 1'b1;
            sram_we_n <= 1'b1;
            drive     <= 1'b0;
          end else begin
            state     <= REQ_IDLE;
            sram_ce_n <= 1'b1;
          end
        end
        REQ_READ: begin
          if (!phase) begin
            phase <= 1'b1;
          end else begin
            // Data has had a full cycle with oe_n low
            rd_data       <= sram_data;
            rd_data_valid <= 1'b1;
            state         <= REQ_IDLE;
            sram_ce_n     <= 1'b1;
            sram_oe_n     <= 1'b1;
          end
        end
        default: state <= REQ_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* pattern_writer.sv */
`timescale 1ns/100ps
`default_nettype none

module pattern_writer import vga_sram_pkg::*; #(
  parameter int ADDR_WIDTH = 20,
  parameter int DATA_WIDTH = 16,
  parameter int H_ACTIVE   = 8,
  parameter int V_ACTIVE   = 4
) (
  input  wire                   clk,
  input  wire                   rst,
  input  wire  [15:0]           seed,
  output logic [ADDR_WIDTH-1:0] wr_addr,
  output logic [DATA_WIDTH-1:0] wr_data,
  output logic                  wr_valid,
  input  wire                   wr_ready,
  output logic                  pattern_done
);

  localparam int FRAME_PIXELS = H_ACTIVE * V_ACTIVE;
  localparam logic [ADDR_WIDTH-1:0] LAST_ADDR = ADDR_WIDTH'(FRAME_PIXELS - 1);

  color_t color;

  // Data follows the address, so it is steady while waiting
  assign color   = pattern_color(32'(wr_addr), seed);
  assign wr_data = DATA_WIDTH'(color);

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_addr      <= '0;
      wr_valid     <= 1'b0;
      pattern_done <= 1'b0;
    end else if (wr_valid && wr_ready) begin
      if (wr_addr == LAST_ADDR) begin
        wr_valid     <= 1'b0;
        pattern_done <= 1'b1;
      end else begin
        wr_addr <= wr_addr + 1'b1;
      end
    end else if (!wr_valid && !pattern_done) begin
      // First request right after reset
      wr_valid <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* pixel_stream.sv */
`timescale 1ns/100ps
`default_nettype none

module pixel_stream import vga_sram_pkg::*; #(
  parameter int ADDR_WIDTH = 20,
  parameter int DATA_WIDTH = 16,
  parameter int H_ACTIVE   = 8,
  parameter int H_FRONT    = 2,
  parameter int H_SYNC     = 2,
  parameter int H_BACK     = 2,
  parameter int V_ACTIVE   = 4,
  parameter int V_FRONT    = 1,
  parameter int V_SYNC     = 1,
  parameter int V_BACK     = 1
) (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   enable,
  output logic [ADDR_WIDTH-1:0] rd_addr,
  output logic                  rd_valid,
  input  wire                   rd_ready,
  input  wire  [DATA_WIDTH-1:0] rd_data,
  input  wire                   rd_data_valid,
  output pixel_word_t           pixel,
  output logic                  pixel_valid
);

  localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
  localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
  localparam int HW           = $clog2(H_TOTAL);
  localparam int VW           = $clog2(V_TOTAL);

  logic [HW-1:0] h_count;
  logic [VW-1:0] v_count;
  logic [HW-1:0] fetch_x;
  logic [VW-1:0] fetch_y;
  logic          pending;
  logic          buf_valid;
  color_t        buf_color;
  color_t        push_color;
  logic          active;
  logic          h_sync_on;
  logic          v_sync_on;
  logic          outstanding;
  logic          word_here;
  logic          advance;

  assign active    = (h_count < HW'(H_ACTIVE)) && (v_count < VW'(V_ACTIVE));
  assign h_sync_on = (h_count >= HW'(H_SYNC_START)) && (h_count < HW'(H_SYNC_START + H_SYNC));
  assign v_sync_on = (v_count >= VW'(V_SYNC_START)) && (v_count < VW'(V_SYNC_START + V_SYNC));

  // At most one word in flight or held, always for the next active position
  assign outstanding = pending && !rd_data_valid;
  assign word_here   = rd_data_valid || buf_valid;
  assign push_color  = buf_valid ? buf_color : color_t'(rd_data[11:0]);

  // Prefetch as soon as the held word is about to be pushed
  assign rd_valid = enable && !outstanding && (!word_here || active);
  assign rd_addr  = ADDR_WIDTH'(fetch_y) * ADDR_WIDTH'(H_ACTIVE) + ADDR_WIDTH'(fetch_x);

  // Blanking pushes at once, active waits for its word
  assign advance = enable && (!active || word_here);

  always_ff @(posedge clk) begin
    pixel_valid <= 1'b0;
    if (rst) begin
      // Start in vertical blanking so the FIFO fills before active video
      h_count   <= '0;
      v_count   <= VW'(V_ACTIVE);
      fetch_x   <= '0;
      fetch_y   <= '0;
      pending   <= 1'b0;
      buf_valid <= 1'b0;
    end else begin
      if (rd_valid && rd_ready) begin
        pending <= 1'b1;
        if (fetch_x == HW'(H_ACTIVE - 1)) begin
          fetch_x <= '0;
          fetch_y <= (fetch_y == VW'(V_ACTIVE - 1)) ? '0 : fetch_y + 1'b1;
        end else begin
          fetch_x <= fetch_x + 1'b1;
        end
      end else if (rd_data_valid) begin
        pending <= 1'b0;
      end

      if (advance) begin
        pixel_valid <= 1'b1;
        if (h_count == HW'(H_TOTAL - 1)) begin
          h_count <= '0;
          v_count <= (v_count == VW'(V_TOTAL - 1)) ? '0 : v_count + 1'b1;
        end else begin
          h_count <= h_count + 1'b1;
        end
      end

      if (advance && active) begin
        buf_valid <= 1'b0;
      end else if (rd_data_valid) begin
        buf_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_data_valid && !(advance && active)) begin
      buf_color <= color_t'(rd_data[11:0]);
    end
    if (advance) begin
      pixel.hsync <= h_sync_on ? SYNC_ACTIVE : ~SYNC_ACTIVE;
      pixel.vsync <= v_sync_on ? SYNC_ACTIVE : ~SYNC_ACTIVE;
      pixel.color <= active ? push_color : '0;
    end
  end

endmodule

`default_nettype wire

/* cdc_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module cdc_fifo #(
  parameter int                    DATA_WIDTH = 14,
  parameter int                    DEPTH_LOG2 = 3,
  parameter logic [DATA_WIDTH-1:0] RESET_DATA = '0
) (
  input  wire                   w_clk,
  input  wire                   w_rst,
  input  wire                   w_inc,
  input  wire  [DATA_WIDTH-1:0] w_data,
  output logic                  w_full,
  output logic                  w_almost_full,
  input  wire                   r_clk,
  input  wire                   r_rst,
  input  wire                   r_inc,
  output logic                  r_empty,
  output logic [DATA_WIDTH-1:0] r_data,
  output logic                  underflow
);

  localparam int DEPTH = 1 << DEPTH_LOG2;

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  logic [DEPTH_LOG2:0] w_bin, w_bin_next, w_gray;
  logic [DEPTH_LOG2:0] w_rgray_q1, w_rgray_q2, w_rbin, w_count;
  logic [DEPTH_LOG2:0] r_bin, r_bin_next, r_gray;
  logic [DEPTH_LOG2:0] r_wgray_q1, r_wgray_q2;
  logic                w_push;
  logic                r_pop;
  logic                r_started;

  function automatic logic [DEPTH_LOG2:0] gray_to_bin(input logic [DEPTH_LOG2:0] g);
    logic [DEPTH_LOG2:0] b;
    b[DEPTH_LOG2] = g[DEPTH_LOG2];
    for (int i = DEPTH_LOG2 - 1; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  // Write side, fill level against the synchronized read pointer
  assign w_rbin        = gray_to_bin(w_rgray_q2);
  assign w_count       = w_bin - w_rbin;
  assign w_full        = (w_count == (DEPTH_LOG2 + 1)'(DEPTH));
  assign w_almost_full = (w_count >= (DEPTH_LOG2 + 1)'(DEPTH - 2));
  assign w_push        = w_inc && !w_full;
  assign w_bin_next    = w_bin + 1'b1;

  always_ff @(posedge w_clk) begin
    if (w_push) begin
      mem[w_bin[DEPTH_LOG2-1:0]] <= w_data;
    end
  end

  always_ff @(posedge w_clk) begin
    if (w_rst) begin
      w_bin      <= '0;
      w_gray     <= '0;
      w_rgray_q1 <= '0;
      w_rgray_q2 <= '0;
    end else begin
      w_rgray_q1 <= r_gray;
      w_rgray_q2 <= w_rgray_q1;
      if (w_push) begin
        w_bin  <= w_bin_next;
        w_gray <= w_bin_next ^ (w_bin_next >> 1);
      end
    end
  end

  // Read side
  assign r_empty    = (r_gray == r_wgray_q2);
  assign r_pop      = r_inc && !r_empty;
  assign r_bin_next = r_bin + 1'b1;

  always_ff @(posedge r_clk) begin
    if (r_rst) begin
      r_bin      <= '0;
      r_gray     <= '0;
      r_wgray_q1 <= '0;
      r_wgray_q2 <= '0;
      r_data     <= RESET_DATA;
      r_started  <= 1'b0;
      underflow  <= 1'b0;
    end else begin
      r_wgray_q1 <= w_gray;
      r_wgray_q2 <= r_wgray_q1;
      if (r_pop) begin
        r_data    <= mem[r_bin[DEPTH_LOG2-1:0]];
        r_bin     <= r_bin_next;
        r_gray    <= r_bin_next ^ (r_bin_next >> 1);
        r_started <= 1'b1;
      end
      // Sticky once the stream has started and then runs dry
      if (r_started && r_empty) begin
        underflow <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* vga_sram.sv */
`timescale 1ns/100ps
`default_nettype none

module vga_sram import vga_sram_pkg::*; #(
  parameter int ADDR_WIDTH      = 20,
  parameter int DATA_WIDTH      = 16,
  parameter int H_ACTIVE        = 8,
  parameter int H_FRONT         = 2,
  parameter int H_SYNC          = 2,
  parameter int H_BACK          = 2,
  parameter int V_ACTIVE        = 4,
  parameter int V_FRONT         = 1,
  parameter int V_SYNC          = 1,
  parameter int V_BACK          = 1,
  parameter int FIFO_DEPTH_LOG2 = 3
) (
  input  wire                   clk,
  input  wire                   pixel_clk,
  input  wire                   rst,
  input  wire  [15:0]           seed,
  output logic [ADDR_WIDTH-1:0] sram_addr,
  inout  wire  [DATA_WIDTH-1:0] sram_data,
  output logic                  sram_we_n,
  output logic                  sram_oe_n,
  output logic                  sram_ce_n,
  output logic [3:0]            vga_red,
  output logic [3:0]            vga_green,
  output logic [3:0]            vga_blue,
  output logic                  vga_hsync,
  output logic                  vga_vsync,
  output logic                  underflow
);

  // FIFO output before the first read, sync inactive and black
  localparam pixel_word_t IDLE_WORD = '{hsync: ~SYNC_ACTIVE, vsync: ~SYNC_ACTIVE, color: '0};

  logic [ADDR_WIDTH-1:0]       wr_addr;
  logic [DATA_WIDTH-1:0]       wr_data;
  logic                        wr_valid;
  logic                        wr_ready;
  logic [ADDR_WIDTH-1:0]       rd_addr;
  logic                        rd_valid;
  logic                        rd_ready;
  logic [DATA_WIDTH-1:0]       rd_data;
  logic                        rd_data_valid;
  logic                        pattern_done;
  logic                        stream_enable;
  pixel_word_t                 stream_pixel;
  logic                        stream_valid;
  logic                        fifo_almost_full;
  logic                        fifo_empty;
  logic [PIXEL_WORD_WIDTH-1:0] fifo_r_data;
  pixel_word_t                 vga_word;

  // Streamer holds off until the frame is written and the FIFO has room
  assign stream_enable = pattern_done && !fifo_almost_full;

  sram_controller #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH)
  ) u_sram_controller (
    .clk          (clk),
    .rst          (rst),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .wr_valid     (wr_valid),
    .wr_ready     (wr_ready),
    .rd_addr      (rd_addr),
    .rd_valid     (rd_valid),
    .rd_ready     (rd_ready),
    .rd_data      (rd_data),
    .rd_data_valid(rd_data_valid),
    .sram_addr    (sram_addr),
    .sram_data    (sram_data),
    .sram_we_n    (sram_we_n),
    .sram_oe_n    (sram_oe_n),
    .sram_ce_n    (sram_ce_n)
  );

  pattern_writer #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH),
    .H_ACTIVE  (H_ACTIVE),
    .V_ACTIVE  (V_ACTIVE)
  ) u_pattern_writer (
    .clk         (clk),
    .rst         (rst),
    .seed        (seed),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .wr_valid    (wr_valid),
    .wr_ready    (wr_ready),
    .pattern_done(pattern_done)
  );

  pixel_stream #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH),
    .H_ACTIVE  (H_ACTIVE),
    .H_FRONT   (H_FRONT),
    .H_SYNC    (H_SYNC),
    .H_BACK    (H_BACK),
    .V_ACTIVE  (V_ACTIVE),
    .V_FRONT   (V_FRONT),
    .V_SYNC    (V_SYNC),
    .V_BACK    (V_BACK)
  ) u_pixel_stream (
    .clk          (clk),
    .rst          (rst),
    .enable       (stream_enable),
    .rd_addr      (rd_addr),
    .rd_valid     (rd_valid),
    .rd_ready     (rd_ready),
    .rd_data      (rd_data),
    .rd_data_valid(rd_data_valid),
    .pixel        (stream_pixel),
    .pixel_valid  (stream_valid)
  );

  cdc_fifo #(
    .DATA_WIDTH(PIXEL_WORD_WIDTH),
    .DEPTH_LOG2(FIFO_DEPTH_LOG2),
    .RESET_DATA(IDLE_WORD)
  ) u_cdc_fifo (
    .w_clk        (clk),
    .w_rst        (rst),
    .w_inc        (stream_valid),
    .w_data       (stream_pixel),
    .w_full       (),
    .w_almost_full(fifo_almost_full),
    .r_clk        (pixel_clk),
    .r_rst        (rst),
    .r_inc        (!fifo_empty),
    .r_empty      (fifo_empty),
    .r_data       (fifo_r_data),
    .underflow    (underflow)
  );

  // Pixel word out to the VGA pins
  assign vga_word  = pixel_word_t'(fifo_r_data);
  assign vga_hsync = vga_word.hsync;
  assign vga_vsync = vga_word.vsync;
  assign vga_red   = vga_word.color.red;
  assign vga_green = vga_word.color.green;
  assign vga_blue  = vga_word.color.blue;

endmodule

`default_nettype wire

/* vga_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module vga_checker import vga_sram_pkg::*; #(
  parameter int H_ACTIVE = 8,
  parameter int H_FRONT  = 2,
  parameter int H_SYNC   = 2,
  parameter int H_BACK   = 2,
  parameter int V_ACTIVE = 4,
  parameter int V_FRONT  = 1,
  parameter int V_SYNC   = 1,
  parameter int V_BACK   = 1
) (
  input  wire        pixel_clk,
  input  wire        rst,
  input  wire [15:0] seed,
  input  wire [3:0]  vga_red,
  input  wire [3:0]  vga_green,
  input  wire [3:0]  vga_blue,
  input  wire        vga_hsync,
  input  wire        vga_vsync,
  input  wire        underflow,
  input  wire [7:0]  probe_x,
  input  wire [7:0]  probe_y,
  input  wire [11:0] probe_color,
  output int         frames_done,
  output int         error_count,
  output int         probe_hits
);

  localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
  localparam int V_SYNC_START = V_ACTIVE + V_FRONT;

  // First full frame after alignment, kept for the repeat check
  logic [13:0] first_frame [H_TOTAL * V_TOTAL];

  int   h;
  int   v;
  logic aligned;
  logic prev_vsync;
  logic underflow_seen;

  initial begin
    frames_done    = 0;
    error_count    = 0;
    probe_hits     = 0;
    h              = 0;
    v              = 0;
    aligned        = 1'b0;
    prev_vsync     = !SYNC_ACTIVE;
    underflow_seen = 1'b0;
  end

  task automatic report(input string name, input logic [13:0] expected,
                        input logic [13:0] actual);
    error_count++;
    $display("Error at %0t: %s expected %0h got %0h (x %0d y %0d)",
             $time, name, expected, actual, h, v);
  endtask

  task automatic check_pixel();
    logic        in_active;
    logic        exp_hsync;
    logic        exp_vsync;
    logic [11:0] exp_color;
    logic [11:0] color;
    logic [13:0] word;
    int          addr;
    color     = {vga_red, vga_green, vga_blue};
    word      = {vga_hsync, vga_vsync, color};
    in_active = (h < H_ACTIVE) && (v < V_ACTIVE);
    addr      = v * H_ACTIVE + h;
    // Frame buffer holds address xor seed, blanking is black
    exp_color = in_active ? (addr[11:0] ^ seed[11:0]) : 12'h000;
    exp_hsync = (h >= H_SYNC_START && h < H_SYNC_START + H_SYNC) ? SYNC_ACTIVE : !SYNC_ACTIVE;
    exp_vsync = (v >= V_SYNC_START && v < V_SYNC_START + V_SYNC) ? SYNC_ACTIVE : !SYNC_ACTIVE;
    if (vga_hsync !== exp_hsync) begin
      report("vga_hsync", 14'(exp_hsync), 14'(vga_hsync));
    end
    if (vga_vsync !== exp_vsync) begin
      report("vga_vsync", 14'(exp_vsync), 14'(vga_vsync));
    end
    if (color !== exp_color) begin
      report("vga_rgb", 14'(exp_color), 14'(color));
    end
    if (in_active && h == int'(probe_x) && v == int'(probe_y)) begin
      probe_hits++;
      if (color !== probe_color) begin
        report("probe vga_rgb", 14'(probe_color), 14'(color));
      end
    end
    if (frames_done == 0) begin
      first_frame[v * H_TOTAL + h] = word;
    end else if (frames_done == 1 && word !== first_frame[v * H_TOTAL + h]) begin
      report("repeated frame word", first_frame[v * H_TOTAL + h], word);
    end
  endtask

  task automatic step_position();
    h++;
    if (h == H_TOTAL) begin
      h = 0;
      v = (v == V_TOTAL - 1) ? 0 : v + 1;
    end
    // Back at the start of the sync line means one frame is complete
    if (h == 0 && v == V_SYNC_START) begin
      frames_done++;
    end
  endtask

  // Outputs change on the rising edge, so the falling edge sees them settled
  always @(negedge pixel_clk) begin
    if (rst) begin
      aligned        = 1'b0;
      frames_done    = 0;
      probe_hits     = 0;
      underflow_seen = 1'b0;
      prev_vsync     = !SYNC_ACTIVE;
      h              = 0;
      v              = 0;
    end else begin
      if (!aligned && prev_vsync != SYNC_ACTIVE && vga_vsync == SYNC_ACTIVE) begin
        aligned = 1'b1;
        h       = 0;
        v       = V_SYNC_START;
      end
      if (aligned) begin
        check_pixel();
        step_position();
      end
      if (underflow && !underflow_seen) begin
        underflow_seen = 1'b1;
        report("underflow", 14'd0, 14'd1);
      end
      prev_vsync = vga_vsync;
    end
  end

endmodule

`default_nettype wire

/* vga_sram_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module vga_sram_assertions (
  input wire clk,
  input wire rst,
  input wire we_n,
  input wire oe_n,
  input wire bus_drive,
  input wire push,
  input wire full
);

  int fail_count = 0;

  // Never write and read the SRAM in the same cycle
  strobes_exclusive: assert property (@(posedge clk) disable iff (rst) !(!we_n && !oe_n))
    else begin
      fail_count++;
      $error("SRAM we_n and oe_n are low together");
    end

  bus_drive_in_write: assert property (@(posedge clk) disable iff (rst) bus_drive |-> !we_n)
    else begin
      fail_count++;
      $error("Controller drives sram_data while we_n is high");
    end

  // A push into a full FIFO would drop a pixel
  no_push_when_full: assert property (@(posedge clk) disable iff (rst) push |-> !full)
    else begin
      fail_count++;
      $error("FIFO write strobe while the FIFO is full");
    end

endmodule

bind sram_controller vga_sram_assertions u_sram_checks (
  .clk      (clk),
  .rst      (rst),
  .we_n     (sram_we_n),
  .oe_n     (sram_oe_n),
  .bus_drive(drive),
  .push     (1'b0),
  .full     (1'b0)
);

bind cdc_fifo vga_sram_assertions u_fifo_checks (
  .clk      (w_clk),
  .rst      (w_rst),
  .we_n     (1'b1),
  .oe_n     (1'b1),
  .bus_drive(1'b0),
  .push     (w_inc),
  .full     (w_full)
);

`default_nettype wire

/* tb_vga_sram.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_vga_sram;

  localparam int ADDR_WIDTH      = 20;
  localparam int DATA_WIDTH      = 16;
  localparam int H_ACTIVE        = 8;
  localparam int H_FRONT         = 2;
  localparam int H_SYNC          = 2;
  localparam int H_BACK          = 2;
  localparam int V_ACTIVE        = 4;
  localparam int V_FRONT         = 1;
  localparam int V_SYNC          = 1;
  localparam int V_BACK          = 1;
  localparam int FIFO_DEPTH_LOG2 = 3;
  localparam int MODEL_AW        = 8;
  localparam int FRAME_TIMEOUT   = 5000;

  logic                  clk;
  logic                  pixel_clk;
  logic                  rst;
  logic [15:0]           seed;
  logic [7:0]            probe_x;
  logic [7:0]            probe_y;
  logic [11:0]           probe_color;
  wire  [ADDR_WIDTH-1:0] sram_addr;
  wire  [DATA_WIDTH-1:0] sram_data;
  wire                   sram_we_n;
  wire                   sram_oe_n;
  wire                   sram_ce_n;
  wire  [3:0]            vga_red;
  wire  [3:0]            vga_green;
  wire  [3:0]            vga_blue;
  wire                   vga_hsync;
  wire                   vga_vsync;
  wire                   underflow;
  int                    frames_done;
  int                    error_count;
  int                    probe_hits;
  int                    tests_run;
  int                    tests_failed;

  logic [DATA_WIDTH-1:0] sram_mem [1 << MODEL_AW];

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // Offset by 3 ns so no pixel_clk edge lands on a clk edge
  initial begin
    pixel_clk = 1'b0;
    #3;
    forever #10 pixel_clk = ~pixel_clk;
  end

  // Asynchronous SRAM model
  initial begin
    for (int i = 0; i < (1 << MODEL_AW); i++) begin
      sram_mem[i] = 16'hc000 | 16'(i);
    end
  end

  assign sram_data = (!sram_ce_n && !sram_oe_n) ? sram_mem[sram_addr[MODEL_AW-1:0]] : 'z;

  // Write data sampled in the middle of the we_n pulse
  always @(negedge clk) begin
    if (!sram_ce_n && !sram_we_n) begin
      sram_mem[sram_addr[MODEL_AW-1:0]] <= sram_data;
    end
  end

  vga_sram #(
    .ADDR_WIDTH     (ADDR_WIDTH),
    .DATA_WIDTH     (DATA_WIDTH),
    .H_ACTIVE       (H_ACTIVE),
    .H_FRONT        (H_FRONT),
    .H_SYNC         (H_SYNC),
    .H_BACK         (H_BACK),
    .V_ACTIVE       (V_ACTIVE),
    .V_FRONT        (V_FRONT),
    .V_SYNC         (V_SYNC),
    .V_BACK         (V_BACK),
    .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
  ) u_vga_sram (
    .clk      (clk),
    .pixel_clk(pixel_clk),
    .rst      (rst),
    .seed     (seed),
    .sram_addr(sram_addr),
    .sram_data(sram_data),
    .sram_we_n(sram_we_n),
    .sram_oe_n(sram_oe_n),
    .sram_ce_n(sram_ce_n),
    .vga_red  (vga_red),
    .vga_green(vga_green),
    .vga_blue (vga_blue),
    .vga_hsync(vga_hsync),
    .vga_vsync(vga_vsync),
    .underflow(underflow)
  );

  vga_checker #(
    .H_ACTIVE(H_ACTIVE),
    .H_FRONT (H_FRONT),
    .H_SYNC  (H_SYNC),
    .H_BACK  (H_BACK),
    .V_ACTIVE(V_ACTIVE),
    .V_FRONT (V_FRONT),
    .V_SYNC  (V_SYNC),
    .V_BACK  (V_BACK)
  ) u_checker (
    .pixel_clk  (pixel_clk),
    .rst        (rst),
    .seed       (seed),
    .vga_red    (vga_red),
    .vga_green  (vga_green),
    .vga_blue   (vga_blue),
    .vga_hsync  (vga_hsync),
    .vga_vsync  (vga_vsync),
    .underflow  (underflow),
    .probe_x    (probe_x),
    .probe_y    (probe_y),
    .probe_color(probe_color),
    .frames_done(frames_done),
    .error_count(error_count),
    .probe_hits (probe_hits)
  );

  function automatic int assertion_failures();
    return u_vga_sram.u_sram_controller.u_sram_checks.fail_count +
           u_vga_sram.u_cdc_fifo.u_fifo_checks.fail_count;
  endfunction

  // New seed and probe go in together with reset, then two frames are checked
  task automatic run_vector(input logic [15:0] vec_seed, input int x, input int y,
                            input logic [11:0] color);
    int errors_before;
    int asserts_before;
    int cycles;
    errors_before  = error_count;
    asserts_before = assertion_failures();
    @(negedge clk);
    seed        = vec_seed;
    probe_x     = 8'(x);
    probe_y     = 8'(y);
    probe_color = color;
    rst         = 1'b1;
    repeat (3) @(negedge clk);
    rst    = 1'b0;
    cycles = 0;
    while (frames_done < 2 && cycles < FRAME_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    tests_run++;
    if (frames_done < 2) begin
      tests_failed++;
      $display("Test %0d seed %h: FAIL, only %0d of 2 frames seen within %0d clk cycles",
               tests_run, vec_seed, frames_done, FRAME_TIMEOUT);
    end else if (probe_hits < 2) begin
      tests_failed++;
      $display("Test %0d seed %h: FAIL, probe pixel (%0d,%0d) was not shown in both frames",
               tests_run, vec_seed, x, y);
    end else if (error_count != errors_before || assertion_failures() != asserts_before) begin
      tests_failed++;
      $display("Test %0d seed %h: FAIL, %0d pixel errors and %0d assertion failures",
               tests_run, vec_seed, error_count - errors_before,
               assertion_failures() - asserts_before);
    end else begin
      $display("Test %0d seed %h: PASS", tests_run, vec_seed);
    end
  endtask

  initial begin
    int          fd;
    int          fields;
    string       line;
    logic [15:0] vec_seed;
    int          vec_x;
    int          vec_y;
    logic [11:0] vec_color;
    rst          = 1'b1;
    seed         = 16'h0000;
    probe_x      = 8'd0;
    probe_y      = 8'd0;
    probe_color  = 12'h000;
    tests_run    = 0;
    tests_failed = 0;
    repeat (3) @(negedge clk);
    rst = 1'b0;
    fd  = $fopen("vga_sram_vectors.txt", "r");
    if (fd == 0) begin
      $display("Cannot open vga_sram_vectors.txt");
      tests_failed++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        // Skip comment and empty lines
        if (line.len() > 1 && line.substr(0, 1) != "//") begin
          fields = $sscanf(line, "%h %d %d %h", vec_seed, vec_x, vec_y, vec_color);
          if (fields == 4) begin
            run_vector(vec_seed, vec_x, vec_y, vec_color);
          end else begin
            $display("Malformed vector line: %s", line);
            tests_failed++;
          end
        end
      end
      $fclose(fd);
    end
    if (tests_run == 0) begin
      $display("No vectors were run");
      tests_failed++;
    end
    $display("Tests run %0d, passed %0d, failed %0d, pixel errors %0d, assertion failures %0d",
             tests_run, tests_run - tests_failed, tests_failed, error_count,
             assertion_failures());
    if (tests_failed == 0 && error_count == 0 && assertion_failures() == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vga_sram_vectors.txt */
// seed(hex) probe_x probe_y expected_color(hex)
// one test per line, the color is 12-bit rgb of the probe pixel
0000 0 0 000
1234 3 1 23f
abcd 7 3 bd2
ffff 5 2 fea
0f0f 0 3 f17
8000 6 0 006
5a5a 1 2 a4b
2c3e 4 1 c32

/* project.f */
vga_sram_pkg.sv
sram_controller.sv
pattern_writer.sv
pixel_stream.sv
cdc_fifo.sv
vga_sram.sv
vga_checker.sv
vga_sram_assertions.sv
tb_vga_sram.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_vga_sram
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert -j 0
FAIL_MSG   ?= SOME TESTS FAILED
SOURCES    := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
